// File: src/drs_cell_reader.sv
`timescale 1ns/100ps

module drs_cell_reader
  import drs_readout_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      start_i,
  input  drs_ctl_t  ctl_i,
  input  adc_word_t adc_data_i,
  output logic      srclk_en_o,
  output adc_word_t fifo_wdata_o,
  output logic      fifo_wen_o,
  output logic      done_o
);

  adc_word_t   adc_iob;
  adc_word_t   adc_q;
  logic        active;
  logic        past_latency;
  read_cnt_t   rd_cnt;
  sample_cnt_t sample_cnt;

  // --------------------
  // adc input flops
  // --------------------

  // adc shares our clock, catch it mid cycle
  always_ff @(negedge clock) begin
    adc_iob <= adc_data_i;
  end

  // back onto the rising edge
  always_ff @(posedge clock) begin
    adc_q <= adc_iob;
  end

  // --------------------
  // channel readout
  // --------------------

  // adc pipeline delay measured in shift clocks
  assign past_latency = rd_cnt > read_cnt_t'(ctl_i.adc_latency);

  always_ff @(posedge clock) begin
    if (reset) begin
      active     <= 1'b0;
      rd_cnt     <= '0;
      sample_cnt <= '0;
      srclk_en_o <= 1'b0;
      fifo_wen_o <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      srclk_en_o <= 1'b0;
      fifo_wen_o <= 1'b0;
      done_o     <= 1'b0;
      if (start_i) begin
        active     <= 1'b1;
        rd_cnt     <= '0;
        sample_cnt <= '0;
      end else if (active) begin
        rd_cnt <= rd_cnt + 1'b1;
        // sample_count_max+1 shift clocks
        srclk_en_o <= rd_cnt <= read_cnt_t'(ctl_i.sample_count_max);
        if (past_latency) begin
          fifo_wen_o <= 1'b1;
          sample_cnt <= sample_cnt + 1'b1;
          // final word of this channel
          if (sample_cnt == ctl_i.sample_count_max) begin
            active <= 1'b0;
            done_o <= 1'b1;
          end
        end
      end
    end
  end

  // fifo data
  always_ff @(posedge clock) begin
    if (active && past_latency) begin
      fifo_wdata_o <= adc_q;
    end
  end

  // every fifo write belongs to an active channel
  assert property (@(posedge clock) disable iff (reset)
    fifo_wen_o |-> $past(active));

endmodule

// File: src/drs_channel_select.sv
`timescale 1ns/100ps

module drs_channel_select
  import drs_chip_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      load_i,
  input  drs_mask_t mask_i,
  input  logic      advance_i,
  output drs_chan_t chan_o,
  output logic      last_o
);

  drs_mask_t remaining;
  drs_mask_t chan_bit;

  // --------------------
  // remaining channels
  // --------------------

  // cleared bit by bit as each channel finishes
  always_ff @(posedge clock) begin
    if (reset) begin
      remaining <= '0;
    end else if (load_i) begin
      remaining <= mask_i;
    end else if (advance_i) begin
      remaining <= remaining & ~chan_bit;
    end
  end

  // --------------------
  // priority search
  // --------------------

  // lowest set bit wins
  // scan top down so the last hit is the lowest
  always_comb begin
    chan_o = '0;
    for (int i = DRS_CHANNELS - 1; i >= 0; i--) begin
      if (remaining[i]) begin
        chan_o = drs_chan_t'(i);
      end
    end
  end

  assign chan_bit = drs_mask_t'(1) << chan_o;

  // nothing above the current channel
  assign last_o = (remaining & ~chan_bit) == '0;

  // a loaded nonzero mask always points at a live channel
  assert property (@(posedge clock) disable iff (reset)
    load_i && (mask_i != '0) |=> remaining[chan_o]);

endmodule

// File: src/drs_chip_pkg.sv
package drs_chip_pkg;

  // --------------------
  // chip address bus
  // --------------------

  typedef logic [3:0] drs_addr_t;

  // address codes from the datasheet
  localparam drs_addr_t ADR_READ_SR  = 4'b1011;
  localparam drs_addr_t ADR_WRITE_SR = 4'b1101;
  localparam drs_addr_t ADR_CONFIG   = 4'b1100;
  localparam drs_addr_t ADR_STANDBY  = 4'b1111;

  // --------------------
  // channels and words
  // --------------------

  // eight inputs plus the reference channel 8
  localparam int unsigned DRS_CHANNELS = 9;

  // channel number 0 to 8, also used as the chip address
  typedef logic [3:0] drs_chan_t;

  // one bit per channel, channel 8 on top
  typedef logic [DRS_CHANNELS-1:0] drs_mask_t;

  // width of the config and write shift registers
  typedef logic [7:0] drs_word_t;

  // bits 7..3 of the config register must always be written as one
  localparam drs_word_t CONFIG_RESERVED = 8'hf8;

  // about 1.5 domino revolutions before triggers are armed
  localparam int unsigned DOMINO_WARMUP = 105;

  // datasheet minimum for the nreset low pulse
  localparam int unsigned CHIP_RESET_CYCLES = 2;

endpackage

// File: src/drs_ctl_regs.sv
`timescale 1ns/100ps

module drs_ctl_regs
  import drs_chip_pkg::*;
  import drs_readout_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  drs_ctl_t  ctl_i,
  input  logic      load_i,
  output drs_ctl_t  ctl_o,
  output drs_mask_t mask_o,
  output drs_word_t config_word_o
);

  // --------------------
  // settings latch
  // --------------------

  // host may change ctl_i at any time
  // the run only sees the copy taken at the accepted command
  always_ff @(posedge clock) begin
    if (reset) begin
      ctl_o <= '0;
    end else if (load_i) begin
      ctl_o <= ctl_i;
    end
  end

  // --------------------
  // derived values
  // --------------------

  // reference channel 8 rides along whenever anything is enabled
  assign mask_o = {|ctl_o.readout_mask, ctl_o.readout_mask};

  // reserved config bits forced high
  assign config_word_o = ctl_o.config_reg | CONFIG_RESERVED;

  // settings only move on a load
  assert property (@(posedge clock) disable iff (reset)
    !load_i |=> $stable(ctl_o));

endmodule

// File: src/drs_readout_pkg.sv
package drs_readout_pkg;

  import drs_chip_pkg::*;

  // --------------------
  // widths
  // --------------------

  localparam int unsigned ADC_WIDTH        = 14;
  localparam int unsigned SAMPLE_CNT_WIDTH = 10;
  localparam int unsigned LATENCY_WIDTH    = 6;
  localparam int unsigned VDD_CNT_WIDTH    = 16;
  // must hold sample_count_max + adc_latency + 1
  localparam int unsigned READ_CNT_WIDTH   = 11;

  typedef logic [ADC_WIDTH-1:0]        adc_word_t;
  typedef logic [SAMPLE_CNT_WIDTH-1:0] sample_cnt_t;
  typedef logic [LATENCY_WIDTH-1:0]    latency_t;
  typedef logic [VDD_CNT_WIDTH-1:0]    vdd_cnt_t;
  typedef logic [READ_CNT_WIDTH-1:0]   read_cnt_t;

  // --------------------
  // run settings
  // --------------------

  typedef struct packed {
    logic        roi_mode;         // 1 = pulse rsrload before each readout
    logic        dmode;            // 1 = wait for trigger, 0 = single shot
    latency_t    adc_latency;      // shift clocks before adc words are valid
    vdd_cnt_t    wait_vdd_clocks;  // supply settling after the domino stops
    sample_cnt_t sample_count_max; // samples per channel minus one
    drs_word_t   config_reg;       // chip config register, reserved bits added later
    drs_word_t   chn_config;       // write shift register pattern
    logic [7:0]  readout_mask;     // channels 0..7 to read
  } drs_ctl_t;

  // chip control pins
  typedef struct packed {
    drs_addr_t addr;
    logic      nreset;
    logic      denable;
    logic      dwrite;
    logic      rsrload;
    logic      srclk_en;
    logic      srin;
  } drs_pins_t;

  typedef enum logic [3:0] {
    INIT,
    IDLE,
    CONFIG_WRITE,
    WSR_WRITE,
    START_RUNNING,
    RUNNING,
    STOP,
    WAIT_VDD,
    INIT_READOUT,
    RSR_LOAD,
    READOUT
  } drs_state_t;

endpackage

// File: src/drs_sequencer.sv
`timescale 1ns/100ps

module drs_sequencer
  import drs_chip_pkg::*;
  import drs_readout_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      start_i,
  input  logic      reinit_i,
  input  logic      configure_i,
  input  logic      trigger_i,
  input  drs_ctl_t  ctl_i,
  input  drs_mask_t mask_i,
  output logic      ctl_load_o,
  output logic      write_start_o,
  output drs_word_t write_word_o,
  input  logic      write_done_i,
  input  logic      writer_srin_i,
  input  logic      writer_srclk_i,
  input  drs_word_t config_word_i,
  output logic      chan_load_o,
  input  drs_chan_t chan_i,
  input  logic      last_i,
  output logic      chan_start_o,
  input  logic      reader_srclk_i,
  input  logic      chan_done_i,
  output drs_pins_t drs_o,
  output logic      busy_o,
  output logic      readout_done_o
);

  drs_state_t state;
  vdd_cnt_t   cnt;
  logic       reinit_q;
  logic       fire;
  drs_pins_t  pins_d;

  // settings are latched on any accepted command
  assign ctl_load_o = (state == IDLE) && !reinit_q && (start_i || configure_i);

  // config word first, then the write shift register
  assign write_word_o = (state == CONFIG_WRITE) ? config_word_i : ctl_i.chn_config;

  // channel list snapshot as the domino stops
  assign chan_load_o = (state == STOP);

  // nothing to read with an empty mask
  assign fire = (|mask_i) && (trigger_i || !ctl_i.dmode);

  // --------------------
  // state machine
  // --------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state          <= INIT;
      cnt            <= '0;
      reinit_q       <= 1'b0;
      write_start_o  <= 1'b0;
      chan_start_o   <= 1'b0;
      busy_o         <= 1'b0;
      readout_done_o <= 1'b0;
    end else begin
      write_start_o  <= 1'b0;
      chan_start_o   <= 1'b0;
      readout_done_o <= 1'b0;
      // remember a reinit until honoured
      if (reinit_i) begin
        reinit_q <= 1'b1;
      end

      case (state)
        INIT: begin
          reinit_q <= reinit_i;
          busy_o   <= 1'b0;
          cnt      <= cnt + 1'b1;
          if (cnt == vdd_cnt_t'(CHIP_RESET_CYCLES - 1)) begin
            state <= IDLE;
            cnt   <= '0;
          end
        end
        IDLE: begin
          cnt <= '0;
          if (ctl_load_o) begin
            if (configure_i) begin
              state         <= CONFIG_WRITE;
              write_start_o <= 1'b1;
            end else begin
              state  <= START_RUNNING;
              busy_o <= 1'b1;
            end
          end
        end
        CONFIG_WRITE: begin
          if (write_done_i) begin
            state         <= WSR_WRITE;
            write_start_o <= 1'b1;
          end
        end
        WSR_WRITE: begin
          if (write_done_i) begin
            state <= IDLE;
          end
        end
        // domino must wrap before a stop position means anything
        START_RUNNING: begin
          cnt <= cnt + 1'b1;
          if (cnt == vdd_cnt_t'(DOMINO_WARMUP - 1)) begin
            state <= RUNNING;
            cnt   <= '0;
          end
        end
        RUNNING: begin
          if (fire) begin
            state <= STOP;
          end
        end
        STOP: begin
          state <= WAIT_VDD;
          cnt   <= '0;
        end
        // supply settling after sampling stops
        WAIT_VDD: begin
          if (cnt == ctl_i.wait_vdd_clocks) begin
            state <= INIT_READOUT;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        INIT_READOUT: begin
          state <= RSR_LOAD;
        end
        RSR_LOAD: begin
          state        <= READOUT;
          chan_start_o <= 1'b1;
        end
        READOUT: begin
          if (chan_done_i) begin
            if (last_i) begin
              state          <= IDLE;
              busy_o         <= 1'b0;
              readout_done_o <= 1'b1;
            end else begin
              chan_start_o <= 1'b1;
            end
          end
        end
        default: begin
          state <= INIT;
        end
      endcase

      // reinit wins everywhere but in the middle of a serial write
      if (reinit_q && state != INIT && state != CONFIG_WRITE && state != WSR_WRITE) begin
        state          <= INIT;
        cnt            <= '0;
        busy_o         <= 1'b0;
        write_start_o  <= 1'b0;
        chan_start_o   <= 1'b0;
        readout_done_o <= 1'b0;
      end
    end
  end

  // --------------------
  // chip pins
  // --------------------

  always_comb begin
    pins_d        = '0;
    pins_d.addr   = ADR_READ_SR;
    pins_d.nreset = 1'b1;
    case (state)
      INIT: begin
        pins_d.addr   = ADR_STANDBY;
        pins_d.nreset = 1'b0;
      end
      CONFIG_WRITE: begin
        pins_d.addr     = ADR_CONFIG;
        pins_d.srclk_en = writer_srclk_i;
        pins_d.srin     = writer_srin_i;
      end
      WSR_WRITE: begin
        pins_d.addr     = ADR_WRITE_SR;
        pins_d.srclk_en = writer_srclk_i;
        pins_d.srin     = writer_srin_i;
      end
      // domino running and sampling
      START_RUNNING, RUNNING: begin
        pins_d.denable = 1'b1;
        pins_d.dwrite  = 1'b1;
      end
      // address settles a cycle ahead of rsrload
      INIT_READOUT: begin
        pins_d.addr = drs_addr_t'(chan_i);
      end
      RSR_LOAD: begin
        pins_d.addr    = drs_addr_t'(chan_i);
        pins_d.rsrload = ctl_i.roi_mode;
      end
      READOUT: begin
        pins_d.addr     = drs_addr_t'(chan_i);
        pins_d.srclk_en = reader_srclk_i;
      end
      default: begin
        pins_d.addr = ADR_READ_SR;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      drs_o <= '{addr: ADR_STANDBY, default: 1'b0};
    end else begin
      drs_o <= pins_d;
    end
  end

  // rsrload is a single pulse per readout
  assert property (@(posedge clock) disable iff (reset)
    drs_o.rsrload |=> !drs_o.rsrload);

endmodule

// File: src/drs_serial_writer.sv
`timescale 1ns/100ps

module drs_serial_writer
  import drs_chip_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      start_i,
  input  drs_word_t word_i,
  output logic      srin_o,
  output logic      srclk_en_o,
  output logic      done_o
);

  drs_word_t  shreg;
  logic [2:0] bit_cnt;

  // --------------------
  // bit sequencing
  // --------------------

  // one bit per enabled shift clock, 8 clocks per word
  always_ff @(posedge clock) begin
    if (reset) begin
      srclk_en_o <= 1'b0;
      bit_cnt    <= '0;
      done_o     <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        srclk_en_o <= 1'b1;
        bit_cnt    <= '0;
      end else if (srclk_en_o) begin
        bit_cnt <= bit_cnt + 3'd1;
        // last bit on the pin this cycle
        if (bit_cnt == 3'd7) begin
          srclk_en_o <= 1'b0;
          done_o     <= 1'b1;
        end
      end
    end
  end

  // --------------------
  // shift register
  // --------------------

  // msb first
  always_ff @(posedge clock) begin
    if (start_i) begin
      shreg <= word_i;
    end else if (srclk_en_o) begin
      shreg <= {shreg[6:0], 1'b0};
    end
  end

  // data only meaningful while clocking
  assign srin_o = srclk_en_o & shreg[7];

  // a word never takes more than 8 clocks
  assert property (@(posedge clock) disable iff (reset)
    srclk_en_o [*8] |=> !srclk_en_o);

endmodule

// File: src/drs_top.sv
`timescale 1ns/100ps

module drs_top
  import drs_chip_pkg::*;
  import drs_readout_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  drs_ctl_t  ctl_i,
  input  logic      start_i,
  input  logic      reinit_i,
  input  logic      configure_i,
  input  logic      trigger_i,
  input  adc_word_t adc_data_i,
  output drs_pins_t drs_o,
  output adc_word_t fifo_wdata_o,
  output logic      fifo_wen_o,
  output logic      busy_o,
  output logic      readout_done_o
);

  // --------------------
  // internal wires
  // --------------------

  drs_ctl_t  ctl;
  drs_mask_t mask;
  drs_word_t config_word;
  drs_word_t write_word;
  drs_chan_t chan;
  logic      ctl_load;
  logic      write_start;
  logic      write_done;
  logic      writer_srin;
  logic      writer_srclk;
  logic      chan_load;
  logic      chan_start;
  logic      chan_done;
  logic      last;
  logic      reader_srclk;

  drs_ctl_regs u_ctl_regs (
    .clock         (clock),
    .reset         (reset),
    .ctl_i         (ctl_i),
    .load_i        (ctl_load),
    .ctl_o         (ctl),
    .mask_o        (mask),
    .config_word_o (config_word)
  );

  drs_serial_writer u_writer (
    .clock      (clock),
    .reset      (reset),
    .start_i    (write_start),
    .word_i     (write_word),
    .srin_o     (writer_srin),
    .srclk_en_o (writer_srclk),
    .done_o     (write_done)
  );

  drs_channel_select u_chan_sel (
    .clock     (clock),
    .reset     (reset),
    .load_i    (chan_load),
    .mask_i    (mask),
    .advance_i (chan_done),
    .chan_o    (chan),
    .last_o    (last)
  );

  drs_cell_reader u_reader (
    .clock        (clock),
    .reset        (reset),
    .start_i      (chan_start),
    .ctl_i        (ctl),
    .adc_data_i   (adc_data_i),
    .srclk_en_o   (reader_srclk),
    .fifo_wdata_o (fifo_wdata_o),
    .fifo_wen_o   (fifo_wen_o),
    .done_o       (chan_done)
  );

  drs_sequencer u_seq (
    .clock          (clock),
    .reset          (reset),
    .start_i        (start_i),
    .reinit_i       (reinit_i),
    .configure_i    (configure_i),
    .trigger_i      (trigger_i),
    .ctl_i          (ctl),
    .mask_i         (mask),
    .ctl_load_o     (ctl_load),
    .write_start_o  (write_start),
    .write_word_o   (write_word),
    .write_done_i   (write_done),
    .writer_srin_i  (writer_srin),
    .writer_srclk_i (writer_srclk),
    .config_word_i  (config_word),
    .chan_load_o    (chan_load),
    .chan_i         (chan),
    .last_i         (last),
    .chan_start_o   (chan_start),
    .reader_srclk_i (reader_srclk),
    .chan_done_i    (chan_done),
    .drs_o          (drs_o),
    .busy_o         (busy_o),
    .readout_done_o (readout_done_o)
  );

endmodule

// File: testbench/drs_chip_model.sv
`timescale 1ns/100ps

module drs_chip_model
  import drs_chip_pkg::*;
  import drs_readout_pkg::*;
(
  input  logic        clock,
  input  drs_pins_t   drs_i,
  output adc_word_t   adc_data_o,
  output drs_word_t   config_word_o,
  output drs_word_t   wsr_word_o,
  output int unsigned config_bits_o,
  output int unsigned wsr_bits_o
);

  localparam logic [31:0] SEED = 32'hd410_a5a9;

  logic [31:0] rnd;

  // --------------------
  // adc
  // --------------------

  // channel tag in the top nibble
  // random low bits
  initial begin
    rnd = $urandom(SEED);
    adc_data_o = '0;
    forever begin
      @(posedge clock);
      #1;
      rnd = $urandom;
      adc_data_o = {drs_i.addr, rnd[ADC_WIDTH-5:0]};
    end
  end

  // --------------------
  // serial registers
  // --------------------

  initial begin
    config_word_o = '0;
    wsr_word_o    = '0;
    config_bits_o = 0;
    wsr_bits_o    = 0;
  end

  // chip shifts on the rising shift clock, msb arrives first
  always @(posedge clock) begin
    if (drs_i.srclk_en) begin
      if (drs_i.addr == ADR_CONFIG) begin
        config_word_o <= {config_word_o[6:0], drs_i.srin};
        config_bits_o <= config_bits_o + 1;
      end else if (drs_i.addr == ADR_WRITE_SR) begin
        wsr_word_o <= {wsr_word_o[6:0], drs_i.srin};
        wsr_bits_o <= wsr_bits_o + 1;
      end
    end
  end

endmodule

// File: testbench/drs_tb.sv
`timescale 1ns/100ps

module drs_tb
  import drs_chip_pkg::*;
  import drs_readout_pkg::*;
();

  typedef struct packed {
    logic [7:0]  mask;
    sample_cnt_t sample_max;
    latency_t    latency;
    vdd_cnt_t    wait_vdd;
    logic        dmode;
    logic        roi_mode;
    drs_word_t   config_reg;
    drs_word_t   chn_config;
    logic        configure;
  } test_row_t;

  localparam int NUM_ROWS        = 5;
  localparam int RESET_CYCLES    = 16;
  localparam int TRIGGER_HOLDOFF = 20;

  logic        clock;
  logic        reset;
  drs_ctl_t    ctl;
  logic        start;
  logic        reinit;
  logic        configure;
  logic        trigger;
  adc_word_t   adc_data;
  drs_pins_t   drs;
  adc_word_t   fifo_wdata;
  logic        fifo_wen;
  logic        busy;
  logic        readout_done;
  drs_word_t   seen_config;
  drs_word_t   seen_wsr;
  int unsigned config_bits;
  int unsigned wsr_bits;

  test_row_t   rows [NUM_ROWS];
  adc_word_t   fifo_q [$];
  int unsigned done_cnt       = 0;
  int unsigned rsrload_cnt    = 0;
  int unsigned nreset_low_cnt = 0;
  int unsigned cycle_cnt      = 0;
  int unsigned cycle_limit    = 0;
  int unsigned error_cnt      = 0;

  drs_top uut (
    .clock          (clock),
    .reset          (reset),
    .ctl_i          (ctl),
    .start_i        (start),
    .reinit_i       (reinit),
    .configure_i    (configure),
    .trigger_i      (trigger),
    .adc_data_i     (adc_data),
    .drs_o          (drs),
    .fifo_wdata_o   (fifo_wdata),
    .fifo_wen_o     (fifo_wen),
    .busy_o         (busy),
    .readout_done_o (readout_done)
  );

  drs_chip_model u_chip (
    .clock         (clock),
    .drs_i         (drs),
    .adc_data_o    (adc_data),
    .config_word_o (seen_config),
    .wsr_word_o    (seen_wsr),
    .config_bits_o (config_bits),
    .wsr_bits_o    (wsr_bits)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // --------------------
  // helpers
  // --------------------

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      error_cnt++;
      $display("Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  // inputs move 1 ns after the rising edge
  task automatic next_drive();
    @(posedge clock);
    #1;
  endtask

  // enabled channels plus channel 8
  function automatic int unsigned channel_count(input logic [7:0] mask);
    int unsigned n;
    n = 0;
    for (int i = 0; i < 8; i++) begin
      n += mask[i];
    end
    if (mask != 0) begin
      n++;
    end
    return n;
  endfunction

  function automatic int unsigned compute_cycle_limit();
    int unsigned total;
    total = 2000;
    for (int i = 0; i < NUM_ROWS; i++) begin
      total += DOMINO_WARMUP + rows[i].wait_vdd + channel_count(rows[i].mask)
             * (rows[i].sample_max + rows[i].latency + 4);
    end
    return total;
  endfunction

  // --------------------
  // stimulus table
  // --------------------

  task automatic fill_table();
    rows[0] = '{mask: 8'h05, sample_max: 10'd15, latency: 6'd3, wait_vdd: 16'd10,
                dmode: 1'b0, roi_mode: 1'b1, config_reg: 8'h02, chn_config: 8'ha5,
                configure: 1'b1};
    rows[1] = '{mask: 8'h80, sample_max: 10'd7, latency: 6'd0, wait_vdd: 16'd0,
                dmode: 1'b1, roi_mode: 1'b0, config_reg: 8'h05, chn_config: 8'h3c,
                configure: 1'b0};
    rows[2] = '{mask: 8'hff, sample_max: 10'd3, latency: 6'd5, wait_vdd: 16'd25,
                dmode: 1'b1, roi_mode: 1'b1, config_reg: 8'h07, chn_config: 8'h81,
                configure: 1'b1};
    rows[3] = '{mask: 8'h42, sample_max: 10'd31, latency: 6'd12, wait_vdd: 16'd3,
                dmode: 1'b0, roi_mode: 1'b0, config_reg: 8'h00, chn_config: 8'h5e,
                configure: 1'b1};
    // empty mask, ends with a reinit
    rows[4] = '{mask: 8'h00, sample_max: 10'd7, latency: 6'd2, wait_vdd: 16'd5,
                dmode: 1'b1, roi_mode: 1'b1, config_reg: 8'h01, chn_config: 8'h00,
                configure: 1'b0};
  endtask

  // --------------------
  // monitors
  // --------------------

  always @(negedge clock) begin
    if (!reset) begin
      if (fifo_wen) begin
        fifo_q.push_back(fifo_wdata);
      end
      if (readout_done) begin
        done_cnt++;
        compare_value("busy_o", busy, 0);
      end
      if (drs.rsrload) begin
        rsrload_cnt++;
      end
      if (!drs.nreset) begin
        nreset_low_cnt++;
      end
    end
  end

  always @(posedge clock) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("Finished with errors");
      $fatal(1, "cycle limit reached");
    end
  end

  // --------------------
  // per row
  // --------------------

  task automatic check_readout(input test_row_t row);
    int unsigned words;
    int unsigned idx;
    logic        enabled;
    words = row.sample_max + 1;
    compare_value("readout_done_o pulses", done_cnt, 1);
    compare_value("busy_o", busy, 0);
    compare_value("rsrload pulses", rsrload_cnt, row.roi_mode ? 1 : 0);
    compare_value("fifo word count", fifo_q.size(), channel_count(row.mask) * words);
    // domino stopped again
    compare_value("drs_o.denable", drs.denable, 0);
    compare_value("drs_o.dwrite", drs.dwrite, 0);
    idx = 0;
    // ascending channels, reference channel 8 after the others
    for (int ch = 0; ch < DRS_CHANNELS; ch++) begin
      if (ch == 8) begin
        enabled = row.mask != 0;
      end else begin
        enabled = row.mask[ch];
      end
      if (enabled) begin
        for (int s = 0; s < words; s++) begin
          compare_value("fifo_wdata_o channel", fifo_q[idx][ADC_WIDTH-1 -: 4], ch);
          idx++;
        end
      end
    end
  endtask

  task automatic run_row(input test_row_t row);
    int unsigned config_before;
    int unsigned wsr_before;
    next_drive();
    ctl.roi_mode         = row.roi_mode;
    ctl.dmode            = row.dmode;
    ctl.adc_latency      = row.latency;
    ctl.wait_vdd_clocks  = row.wait_vdd;
    ctl.sample_count_max = row.sample_max;
    ctl.config_reg       = row.config_reg;
    ctl.chn_config       = row.chn_config;
    ctl.readout_mask     = row.mask;
    done_cnt    = 0;
    rsrload_cnt = 0;
    fifo_q.delete();

    if (row.configure) begin
      config_before = config_bits;
      wsr_before    = wsr_bits;
      configure = 1'b1;
      next_drive();
      configure = 1'b0;
      do @(negedge clock); while (wsr_bits != wsr_before + 8);
      compare_value("config bits", config_bits - config_before, 8);
      compare_value("config word", seen_config, row.config_reg | CONFIG_RESERVED);
      compare_value("write sr word", seen_wsr, row.chn_config);
      // idle again once the write address is released
      while (drs.addr == ADR_WRITE_SR) @(negedge clock);
    end

    next_drive();
    start = 1'b1;
    next_drive();
    start = 1'b0;

    if (row.mask == 0) begin
      repeat (DOMINO_WARMUP + TRIGGER_HOLDOFF) @(negedge clock);
      next_drive();
      trigger = 1'b1;
      repeat (TRIGGER_HOLDOFF) next_drive();
      trigger = 1'b0;
      compare_value("fifo words with empty mask", fifo_q.size(), 0);
      compare_value("busy_o", busy, 1);
      nreset_low_cnt = 0;
      next_drive();
      reinit = 1'b1;
      next_drive();
      reinit = 1'b0;
      while (busy) @(negedge clock);
      while (drs.nreset) @(negedge clock);
      while (!drs.nreset) @(negedge clock);
      compare_value("nreset low cycles", nreset_low_cnt, CHIP_RESET_CYCLES);
      compare_value("readout_done_o pulses", done_cnt, 0);
    end else begin
      // continuous mode holds until the trigger
      if (row.dmode) begin
        repeat (DOMINO_WARMUP + TRIGGER_HOLDOFF) @(negedge clock);
        compare_value("fifo words before trigger", fifo_q.size(), 0);
        compare_value("busy_o", busy, 1);
        // domino running while armed
        compare_value("drs_o.denable", drs.denable, 1);
        compare_value("drs_o.dwrite", drs.dwrite, 1);
        next_drive();
        trigger = 1'b1;
        next_drive();
        trigger = 1'b0;
      end
      do @(negedge clock); while (!readout_done);
      repeat (2) @(negedge clock);
      check_readout(row);
    end
  endtask

  // --------------------
  // main
  // --------------------

  initial begin
    reset     = 1'b1;
    ctl       = '0;
    start     = 1'b0;
    reinit    = 1'b0;
    configure = 1'b0;
    trigger   = 1'b0;
    fill_table();
    cycle_limit = compute_cycle_limit();

    @(negedge clock);
    compare_value("drs_o.addr in reset", drs.addr, ADR_STANDBY);
    compare_value("drs_o.nreset in reset", drs.nreset, 0);
    compare_value("drs_o control pins in reset",
                  {drs.denable, drs.dwrite, drs.rsrload, drs.srclk_en, drs.srin}, 0);
    compare_value("fifo_wen_o in reset", fifo_wen, 0);
    compare_value("busy_o in reset", busy, 0);
    compare_value("readout_done_o in reset", readout_done, 0);
    // first reset edge already behind us
    repeat (RESET_CYCLES - 1) @(posedge clock);
    #1;
    reset = 1'b0;

    // power-up chip reset
    // pin register holds its reset value until the first edge
    @(posedge clock);
    #1;
    nreset_low_cnt = 0;
    do @(negedge clock); while (!drs.nreset);
    compare_value("nreset low cycles after power-up", nreset_low_cnt, CHIP_RESET_CYCLES);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end

    if (error_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: vlog.f
src/drs_chip_pkg.sv
src/drs_readout_pkg.sv
src/drs_ctl_regs.sv
src/drs_serial_writer.sv
src/drs_channel_select.sv
src/drs_cell_reader.sv
src/drs_sequencer.sv
src/drs_top.sv
testbench/drs_chip_model.sv
testbench/drs_tb.sv
